//--- bench/clockGen.sv
/*
  testbench clock and reset.
  8 ns clock, synchronous reset held low for two edges.
*/
`timescale 1ns/1ps

module clockGen (
    output logic CLK40,
    output logic RESETn
);

    // free running clock.
    initial begin
        CLK40 = 1'b0;
        forever #4 CLK40 = ~CLK40;
    end

    // release just after the second edge.
    initial begin
        RESETn = 1'b0;
        repeat (2) @(posedge CLK40);
        #1;
        RESETn = 1'b1;
    end

endmodule

//--- bench/localBusTb.sv
/*
  directed testbench for the local bus termination block.
  register, rtc, unmapped and dropped cycles against the bus timing.
*/
`timescale 1ns/1ps

module localBusTb
    import localBusPkg::*;
();

    // event points, in edges after the edge that samples tsN low.
    localparam waitCountT REG_ACK_AT  = 7'd3;
    localparam waitCountT RTC_EN_AT   = 7'd2;
    localparam waitCountT RTC_TA_AT   = RTC_WAIT + 7'd4;
    localparam waitCountT RTC_OFF_AT  = RTC_TA_AT + RTC_HOLD + 7'd1;
    localparam waitCountT MISS_TEA_AT = waitCountT'(BUS_TIMEOUT) + 7'd1;
    localparam waitCountT WAIT_LIMIT  = 7'd100;
    localparam addrT      RTC_ADDR    = {RTC_PAGE, 16'h0040};
    localparam addrT      MISS_ADDR   = 32'h00D0_0100;
    localparam addrT      OUTER_ADDR  = 32'h0040_0000;
    // 40 tests of up to 100 clocks.
    localparam int        WATCHDOG_NS = 40 * 100 * 8;

    logic CLK40;
    logic RESETn;
    logic tsN;
    addrT addr;
    logic write;
    dataT dataIn;
    dataT dataOut;
    logic taN;
    logic teaN;
    logic rtcEnN;

    // register model.
    dataT expRegs [REG_COUNT];
    int   seed;
    int   dataErrors;
    int   countErrors;
    int   levelErrors;
    int   protocolErrors;

    // trace of the current cycle, zero means not seen.
    waitCountT cycleNo;
    waitCountT taAt;
    waitCountT teaAt;
    waitCountT enLowAt;
    waitCountT enHighAt;
    waitCountT taPulses;
    waitCountT teaPulses;

    clockGen clocks (
        .CLK40  (CLK40),
        .RESETn (RESETn)
    );

    localBusTop UUT (
        .CLK40   (CLK40),
        .RESETn  (RESETn),
        .tsN     (tsN),
        .addr    (addr),
        .write   (write),
        .dataIn  (dataIn),
        .dataOut (dataOut),
        .taN     (taN),
        .teaN    (teaN),
        .rtcEnN  (rtcEnN)
    );

    task automatic checkData(input string name, input dataT expected, input dataT actual);
        if (actual !== expected) begin
            dataErrors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkCount(input string name, input waitCountT expected,
                              input waitCountT actual);
        if (actual !== expected) begin
            countErrors++;
            $display("error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            levelErrors++;
            $display("error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    function automatic addrT regAddr(input regIndexT idx);
        return {REG_PAGE, 12'h000, idx, 2'b00};
    endfunction

    // one clock, sampled 1 ns after the edge.
    task automatic nextEdge();
        @(posedge CLK40);
        #1;
        cycleNo = cycleNo + 7'd1;
        if (!taN) begin
            taPulses = taPulses + 7'd1;
            if (taAt == '0)
                taAt = cycleNo;
        end
        if (!teaN) begin
            teaPulses = teaPulses + 7'd1;
            if (teaAt == '0)
                teaAt = cycleNo;
        end
        if (!rtcEnN && enLowAt == '0)
            enLowAt = cycleNo;
        if (rtcEnN && enLowAt != '0 && enHighAt == '0)
            enHighAt = cycleNo;
    endtask

    // strobe for one clock, trace restarts at edge 0.
    task automatic startCycle(input addrT a, input logic w, input dataT d);
        tsN    = 1'b0;
        addr   = a;
        write  = w;
        dataIn = d;
        @(posedge CLK40);
        #1;
        tsN       = 1'b1;
        cycleNo   = '0;
        taAt      = '0;
        teaAt     = '0;
        enLowAt   = '0;
        enHighAt  = '0;
        taPulses  = '0;
        teaPulses = '0;
    endtask

    task automatic watchUntil(input waitCountT last);
        while (cycleNo < last)
            nextEdge();
    endtask

    task automatic busCycle(input string name, input addrT a, input logic w, input dataT d,
                            output waitCountT cycles, output dataT readData,
                            output logic errorTerm);
        startCycle(a, w, d);
        while (taAt == '0 && teaAt == '0 && cycleNo < WAIT_LIMIT)
            nextEdge();
        if (taAt == '0 && teaAt == '0) begin
            protocolErrors++;
            $display("%s: no taN or teaN within %0d cycles", name, WAIT_LIMIT);
        end
        cycles    = (taAt != '0) ? taAt : teaAt;
        readData  = dataOut;
        errorTerm = (teaAt != '0);
        // one more edge, the open cycle closes here.
        nextEdge();
    endtask

    task automatic regAccess(input string name, input regIndexT idx, input logic w,
                             input dataT d);
        waitCountT cycles;
        dataT      readData;
        logic      errorTerm;
        busCycle(name, regAddr(idx), w, d, cycles, readData, errorTerm);
        checkCount(name, REG_ACK_AT, cycles);
        checkCount(name, 7'd1, taPulses);
        checkBit(name, 1'b0, errorTerm);
        if (w)
            expRegs[idx] = d;
        else
            checkData(name, expRegs[idx], readData);
    endtask

    task automatic verifyRtcTiming(input string name);
        checkCount({name, " enable low"}, RTC_EN_AT, enLowAt);
        checkCount({name, " taN"}, RTC_TA_AT, taAt);
        checkCount({name, " taN pulses"}, 7'd1, taPulses);
        checkCount({name, " enable release"}, RTC_OFF_AT, enHighAt);
        checkCount({name, " teaN pulses"}, 7'd0, teaPulses);
    endtask

    task automatic resetTest();
        checkBit("reset taN", 1'b1, taN);
        checkBit("reset teaN", 1'b1, teaN);
        checkBit("reset rtcEnN", 1'b1, rtcEnN);
        for (int i = 0; i < REG_COUNT; i++)
            regAccess($sformatf("reset read %0d", i), regIndexT'(i), 1'b0, '0);
    endtask

    task automatic regTest();
        dataT word;
        for (int i = 0; i < REG_COUNT; i++) begin
            word = dataT'($random(seed));
            regAccess($sformatf("write reg %0d", i), regIndexT'(i), 1'b1, word);
        end
        for (int i = 0; i < REG_COUNT; i++)
            regAccess($sformatf("readback reg %0d", i), regIndexT'(i), 1'b0, '0);
    endtask

    task automatic rtcTest(input logic w);
        startCycle(RTC_ADDR, w, dataT'($random(seed)));
        watchUntil(RTC_OFF_AT + 7'd3);
        verifyRtcTiming(w ? "rtc write" : "rtc read");
    endtask

    task automatic missTest();
        startCycle(MISS_ADDR, 1'b0, '0);
        watchUntil(MISS_TEA_AT + 7'd3);
        checkCount("miss teaN", MISS_TEA_AT, teaAt);
        checkCount("miss teaN pulses", 7'd1, teaPulses);
        checkCount("miss taN pulses", 7'd0, taPulses);
        regAccess("read after miss", 2'd0, 1'b0, '0);
    endtask

    task automatic ignoredTest();
        // strobe outside the local window.
        startCycle(OUTER_ADDR, 1'b0, '0);
        watchUntil(waitCountT'(BUS_TIMEOUT) + 7'd5);
        checkCount("outside taN pulses", 7'd0, taPulses);
        checkCount("outside teaN pulses", 7'd0, teaPulses);
        // second strobe into an open rtc cycle.
        startCycle(RTC_ADDR, 1'b0, '0);
        watchUntil(7'd10);
        tsN  = 1'b0;
        addr = regAddr(2'd1);
        nextEdge();
        tsN = 1'b1;
        watchUntil(RTC_OFF_AT + 7'd3);
        verifyRtcTiming("rtc with extra strobe");
        regAccess("read after rtc", 2'd1, 1'b0, '0);
    endtask

    // ends a stalled run.
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        tsN            = 1'b1;
        addr           = '0;
        write          = 1'b0;
        dataIn         = '0;
        seed           = 56369;
        dataErrors     = 0;
        countErrors    = 0;
        levelErrors    = 0;
        protocolErrors = 0;
        cycleNo        = '0;
        foreach (expRegs[i])
            expRegs[i] = REG_RESET;
        @(posedge RESETn);
        @(posedge CLK40);
        #1;
        resetTest();
        regTest();
        rtcTest(1'b0);
        rtcTest(1'b1);
        missTest();
        ignoredTest();
        $display("errors: data %0d, count %0d, level %0d, protocol %0d",
                 dataErrors, countErrors, levelErrors, protocolErrors);
        if (dataErrors + countErrors + levelErrors + protocolErrors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- build.f
logic/localBusPkg.sv
logic/addressDecode.sv
logic/rtcCycle.sv
logic/configRegs.sv
logic/transferAck.sv
logic/localBusTop.sv
bench/clockGen.sv
bench/localBusTb.sv

//--- logic/addressDecode.sv
/*
  local bus address decoder.
  samples the cpu start strobe and turns it into a one-cycle decoded start.
*/
`timescale 1ns/1ps

module addressDecode
    import localBusPkg::*;
(
    input  logic       CLK40,
    input  logic       RESETn,
    input  logic       tsN,
    input  addrT       addr,
    input  logic       write,
    input  logic       done,
    output cycleStartT start
);

    // sampled cpu request.
    logic tsQ;
    addrT addrQ;
    logic writeQ;

    // high from accepted start until done.
    logic cycleOpen;

    logic inWindow;
    logic rtcHit;
    logic regHit;
    logic accept;

    assign inWindow = (addrQ[31:20] == LOCAL_WINDOW);
    assign rtcHit   = inWindow && (addrQ[31:16] == RTC_PAGE);
    assign regHit   = inWindow && (addrQ[31:16] == REG_PAGE);
    // strobes outside the window or during an open cycle fall through.
    assign accept   = !tsQ && inWindow && !cycleOpen;

    // address and direction ride along with the strobe.
    always_ff @(posedge CLK40) begin
        addrQ  <= addr;
        writeQ <= write;
    end

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            tsQ       <= 1'b1;
            start     <= '0;
            cycleOpen <= 1'b0;
        end else begin
            tsQ   <= tsN;
            // start lives for one clock only.
            start <= '0;
            if (accept) begin
                start.rtcSel  <= rtcHit;
                start.regSel  <= regHit;
                // in the window but no page claims it.
                start.missSel <= !rtcHit && !regHit;
                start.write   <= writeQ;
                start.index   <= addrQ[3:2];
                cycleOpen     <= 1'b1;
            end else if (done) begin
                cycleOpen <= 1'b0;
            end
        end
    end

endmodule

//--- logic/configRegs.sv
/*
  bridge configuration register bank.
  four word registers, fixed two-cycle acknowledge, registered read data.
*/
`timescale 1ns/1ps

module configRegs
    import localBusPkg::*;
(
    input  logic       CLK40,
    input  logic       RESETn,
    input  cycleStartT start,
    input  dataT       dataIn,
    output dataT       dataOut,
    output logic       regAck
);

    regStateT state;
    dataT     regFile [REG_COUNT];

    // request captured on the decoded start.
    regIndexT indexQ;
    logic     writeQ;
    dataT     dataQ;

    always_ff @(posedge CLK40) begin
        if (start.regSel) begin
            indexQ <= start.index;
            writeQ <= start.write;
            dataQ  <= dataIn;
        end
    end

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            state   <= regIdle;
            regAck  <= 1'b0;
            dataOut <= REG_RESET;
            for (int i = 0; i < REG_COUNT; i++) begin
                regFile[i] <= REG_RESET;
            end
        end else begin
            // ack is a single clock.
            regAck <= 1'b0;
            case (state)
                regIdle: begin
                    if (start.regSel) begin
                        state <= regBusy;
                    end
                end
                regBusy: begin
                    // access lands as the ack state is entered.
                    if (writeQ) begin
                        regFile[indexQ] <= dataQ;
                    end else begin
                        dataOut <= regFile[indexQ];
                    end
                    regAck <= 1'b1;
                    state  <= localBusPkg::regAck;
                end
                // state literal shares its name with the ack port.
                localBusPkg::regAck: begin
                    state <= regIdle;
                end
                default: begin
                    state <= regIdle;
                end
            endcase
        end
    end

endmodule

//--- logic/localBusPkg.sv
/*
  shared definitions for the local bus termination block.
  bus types, address map, cycle timing and the decoded start word.
*/
package localBusPkg;

    // bus and counter widths.
    typedef logic [31:0] addrT;
    typedef logic [31:0] dataT;
    typedef logic [6:0]  waitCountT;
    typedef logic [4:0]  toCountT;
    typedef logic [1:0]  regIndexT;

    // address map, upper address bits.
    localparam logic [11:0] LOCAL_WINDOW = 12'h00D;
    localparam logic [15:0] RTC_PAGE     = 16'h00DC;
    localparam logic [15:0] REG_PAGE     = 16'h00DE;

    // rtc chip access time, counted in wait cycles.
    localparam waitCountT RTC_WAIT = 7'd80;
    // enable stays low this long after the ack.
    localparam waitCountT RTC_HOLD = 7'd2;

    // clocks without ack before teaN.
    localparam toCountT BUS_TIMEOUT = 5'd20;

    // configuration register bank.
    localparam int   REG_COUNT = 4;
    localparam dataT REG_RESET = 32'h0000_0000;

    // one-cycle decoded start, at most one select set.
    typedef struct packed {
        logic     rtcSel;
        logic     regSel;
        logic     missSel;
        logic     write;
        regIndexT index;
    } cycleStartT;

    typedef enum logic [2:0] {rtcIdle, rtcWait, rtcAck, rtcHold, rtcRelease} rtcStateT;

    typedef enum logic [1:0] {regIdle, regBusy, regAck} regStateT;

endpackage

//--- logic/localBusTop.sv
/*
  local bus slow-device termination, top level.
  decoder, rtc and register engines, and the termination merger.
*/
`timescale 1ns/1ps

module localBusTop
    import localBusPkg::*;
(
    input  logic CLK40,
    input  logic RESETn,
    input  logic tsN,
    input  addrT addr,
    input  logic write,
    input  dataT dataIn,
    output dataT dataOut,
    output logic taN,
    output logic teaN,
    output logic rtcEnN
);

    // decoded start, fanned out to every engine.
    cycleStartT start;

    // engine acks and cycle close.
    logic rtcAck;
    logic regAck;
    logic rtcIdleNext;
    logic done;

    addressDecode decode (
        .CLK40  (CLK40),
        .RESETn (RESETn),
        .tsN    (tsN),
        .addr   (addr),
        .write  (write),
        .done   (done),
        .start  (start)
    );

    rtcCycle rtcEngine (
        .CLK40       (CLK40),
        .RESETn      (RESETn),
        .start       (start),
        .rtcEnN      (rtcEnN),
        .rtcAck      (rtcAck),
        .rtcIdleNext (rtcIdleNext)
    );

    configRegs regEngine (
        .CLK40   (CLK40),
        .RESETn  (RESETn),
        .start   (start),
        .dataIn  (dataIn),
        .dataOut (dataOut),
        .regAck  (regAck)
    );

    transferAck termination (
        .CLK40       (CLK40),
        .RESETn      (RESETn),
        .start       (start),
        .rtcAck      (rtcAck),
        .regAck      (regAck),
        .rtcIdleNext (rtcIdleNext),
        .taN         (taN),
        .teaN        (teaN),
        .done        (done)
    );

endmodule

//--- logic/rtcCycle.sv
/*
  battery clock access engine.
  holds the chip enable low for the long access time, then acknowledges.
*/
`timescale 1ns/1ps

module rtcCycle
    import localBusPkg::*;
(
    input  logic       CLK40,
    input  logic       RESETn,
    input  cycleStartT start,
    output logic       rtcEnN,
    output logic       rtcAck,
    output logic       rtcIdleNext
);

    rtcStateT  state;
    // wait count, reused for the hold phase.
    waitCountT waitCount;

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            state       <= rtcIdle;
            waitCount   <= '0;
            rtcEnN      <= 1'b1;
            rtcAck      <= 1'b0;
            rtcIdleNext <= 1'b0;
        end else begin
            // both pulses default low.
            rtcAck      <= 1'b0;
            rtcIdleNext <= 1'b0;
            case (state)
                rtcIdle: begin
                    if (start.rtcSel) begin
                        rtcEnN <= 1'b0;
                        state  <= rtcWait;
                    end
                end
                rtcWait: begin
                    // counts 0 up to RTC_WAIT.
                    if (waitCount == RTC_WAIT) begin
                        state <= localBusPkg::rtcAck;
                    end else begin
                        waitCount <= waitCount + 1'b1;
                    end
                end
                // state literal shares its name with the ack port.
                localBusPkg::rtcAck: begin
                    rtcAck    <= 1'b1;
                    waitCount <= '0;
                    state     <= rtcHold;
                end
                rtcHold: begin
                    // chip hold time, enable still low.
                    waitCount <= waitCount + 1'b1;
                    if (waitCount == RTC_HOLD - 1'b1) begin
                        state <= rtcRelease;
                    end
                end
                rtcRelease: begin
                    rtcEnN      <= 1'b1;
                    rtcIdleNext <= 1'b1;
                    waitCount   <= '0;
                    state       <= rtcIdle;
                end
                default: begin
                    state <= rtcIdle;
                end
            endcase
        end
    end

endmodule

//--- logic/transferAck.sv
/*
  cpu cycle termination.
  merges engine acks into taN, raises teaN on timeout, ends the open cycle.
*/
`timescale 1ns/1ps

module transferAck
    import localBusPkg::*;
(
    input  logic       CLK40,
    input  logic       RESETn,
    input  cycleStartT start,
    input  logic       rtcAck,
    input  logic       regAck,
    input  logic       rtcIdleNext,
    output logic       taN,
    output logic       teaN,
    output logic       done
);

    // timeout counter, armed by unmapped cycles only.
    toCountT toCount;
    toCountT toNext;
    logic    toArmed;

    // acks are registered pulses, taN follows them directly.
    assign taN = !(rtcAck || regAck);

    // rtc cycles close on the enable release, not on taN.
    assign done = regAck || !teaN || rtcIdleNext;

    assign toNext = toCount + 1'b1;

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            toArmed <= 1'b0;
            toCount <= '0;
            teaN    <= 1'b1;
        end else begin
            // teaN is a one-clock pulse.
            teaN <= 1'b1;
            if (start.missSel) begin
                // start clock already counts as one.
                toArmed <= 1'b1;
                toCount <= 5'd1;
            end else if (toArmed) begin
                toCount <= toNext;
                if (toNext == BUS_TIMEOUT) begin
                    teaN    <= 1'b0;
                    toArmed <= 1'b0;
                    toCount <= '0;
                end
            end
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# compile and run the local bus testbench with verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module localBusTb -f build.f -o localBusSim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/localBusSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    echo "result: passed"
    exit 0
else
    echo "result: failed"
    exit 1
fi
